//--- verilog.f
+incdir+verilog
verilog/wb_pkg.sv
verilog/fetch_pkg.sv
verilog/fetch_cache.sv
verilog/instr_queue.sv
verilog/wb_read_master.sv
verilog/fetch_ctrl.sv
verilog/fetch_unit.sv
sim/fetch_checker.sv
sim/tb_fetch_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_fetch_unit -o tb_fetch_unit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_fetch_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "SIMULATION PASSED" sim.log; then
    exit 0
fi
exit 1

//--- sim/tb_fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_config.svh"

module tb_fetch_unit;

    // about twice the worst-case length of all tests.
    localparam int MAX_CYCLES = 4000;

    logic                    clk = 1'b0;
    logic                    rstn;
    logic                    redirect;
    fetch_pkg::pc_t          redirect_pc;
    logic                    pop;
    fetch_pkg::fetch_entry_t instr;
    logic                    instr_valid;
    wb_pkg::wb_req_t         wb_req;
    wb_pkg::wb_rsp_t         wb_rsp = '0;
    logic                    clear_reads;
    logic                    test_done;
    int                      test_id;
    fetch_pkg::pc_t          loop_start;
    int                      loop_len;
    logic                    report;
    int                      failed;
    int                      cycles = 0;
    int                      waits = 0;
    logic                    busy = 1'b0;
    integer                  seed = 32'h4556ef7a;

    fetch_unit fetch_unit_i (
        .clk(clk), .rstn(rstn),
        .i_redirect(redirect), .i_redirect_pc(redirect_pc),
        .i_pop(pop), .o_instr(instr), .o_instr_valid(instr_valid),
        .o_wb_req(wb_req), .i_wb_rsp(wb_rsp)
    );

    fetch_checker check_i (
        .clk(clk), .rstn(rstn),
        .i_redirect(redirect), .i_redirect_pc(redirect_pc),
        .i_instr(instr), .i_instr_valid(instr_valid),
        .i_wb_req(wb_req), .i_wb_rsp(wb_rsp),
        .i_clear_reads(clear_reads), .i_test_done(test_done), .i_test_id(test_id),
        .i_loop_start(loop_start), .i_loop_len(loop_len),
        .i_report(report), .o_failed(failed)
    );

    always #20 clk = ~clk;

    function automatic fetch_pkg::instr_t mem_word(input fetch_pkg::pc_t adr);
        logic [31:0] w;
        w = 32'(adr) ^ 32'h4556ef7a;
        return (w << adr[2:0]) | (w >> (6'd32 - adr[2:0]));
    endfunction

    // memory slave, 0 to 3 wait states per read.
    always @(negedge clk) begin
        if (!rstn || wb_rsp.ack) begin
            wb_rsp.ack = 1'b0;
            busy = 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!busy) begin
                busy = 1'b1;
                waits = $random(seed) & 3;
            end
            if (waits == 0) begin
                wb_rsp.ack = 1'b1;
                wb_rsp.dat = mem_word(wb_req.adr);
            end else begin
                waits--;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic count_entries(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(negedge clk);
            if (instr_valid) begin
                seen++;
            end
        end
    endtask

    task automatic wait_for_pc(input fetch_pkg::pc_t pc);
        @(negedge clk);
        while (!(instr_valid && instr.pc == pc)) begin
            @(negedge clk);
        end
    endtask

    task automatic jump(input fetch_pkg::pc_t pc, input logic clear);
        redirect    = 1'b1;
        redirect_pc = pc;
        clear_reads = clear;
        @(negedge clk);
        redirect    = 1'b0;
        clear_reads = 1'b0;
    endtask

    task automatic end_test(input int id);
        test_id   = id;
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
    endtask

    // the jump back is issued while the last word of the pass is delivered.
    task automatic run_loop(input fetch_pkg::pc_t start, input int len, input int id);
        fetch_pkg::pc_t last;
        last       = start + fetch_pkg::pc_t'(len - 1);
        loop_start = start;
        loop_len   = len;
        jump(start, 1'b0);
        wait_for_pc(last);
        jump(start, 1'b1);
        wait_for_pc(last);
        end_test(id);
    endtask

    initial begin
        rstn        = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        pop         = 1'b0;
        clear_reads = 1'b0;
        test_done   = 1'b0;
        test_id     = 0;
        loop_start  = '0;
        loop_len    = 0;
        report      = 1'b0;
        repeat (5) @(negedge clk);
        rstn = 1'b1;

        pop = 1'b1;
        count_entries(32);
        end_test(1);

        // long enough for the queue to fill completely.
        pop = 1'b0;
        repeat (150) @(negedge clk);
        pop = 1'b1;
        count_entries(40);
        end_test(2);

        // leave a few entries queued so the flush has something to drop.
        pop = 1'b0;
        repeat (20) @(negedge clk);
        jump(16'h0100, 1'b0);
        pop = 1'b1;
        count_entries(8);
        end_test(3);

        run_loop(16'h0200, 6, 4);
        run_loop(16'h0300, 9, 5);

        // back-to-back redirects with pops held high.
        jump(16'h0400, 1'b0);
        repeat (3) @(negedge clk);
        jump(16'h0410, 1'b0);
        jump(16'h0420, 1'b0);
        count_entries(4);
        end_test(6);

        report = 1'b1;
        @(negedge clk);
        report = 1'b0;
        if (failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/fetch_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_config.svh"

module fetch_checker (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          i_redirect,
    input  wire fetch_pkg::pc_t          i_redirect_pc,
    input  wire fetch_pkg::fetch_entry_t i_instr,
    input  wire                          i_instr_valid,
    input  wire wb_pkg::wb_req_t         i_wb_req,
    input  wire wb_pkg::wb_rsp_t         i_wb_rsp,
    input  wire                          i_clear_reads,
    input  wire                          i_test_done,
    input  var int                       i_test_id,
    input  wire fetch_pkg::pc_t          i_loop_start,
    input  var int                       i_loop_len,
    input  wire                          i_report,
    output int                           o_failed
);

    fetch_pkg::pc_t expect_pc;
    // completed bus reads per word address.
    int reads [fetch_pkg::pc_t];
    int test_errors;
    int passed;

    function automatic fetch_pkg::instr_t mem_word(input fetch_pkg::pc_t adr);
        logic [31:0] w;
        w = 32'(adr) ^ 32'h4556ef7a;
        return (w << adr[2:0]) | (w >> (6'd32 - adr[2:0]));
    endfunction

    function automatic int reads_of(input fetch_pkg::pc_t adr);
        return reads.exists(adr) ? reads[adr] : 0;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1: return "sequential fetch";
            2: return "back-pressure";
            3: return "redirect flush";
            4: return "cache hits";
            5: return "fifo replacement";
            default: return "empty pop";
        endcase
    endfunction

    task automatic check_loop_reads(input logic want_reads);
        fetch_pkg::pc_t a;
        for (int k = 0; k < i_loop_len; k++) begin
            a = i_loop_start + fetch_pkg::pc_t'(k);
            if ((reads_of(a) != 0) != want_reads) begin
                $display("Error at %0t ns: address %h read %0d times in the second pass",
                         $time, a, reads_of(a));
                test_errors++;
            end
        end
    endtask

    task automatic finish_test();
        if (i_test_id == 4) begin
            check_loop_reads(1'b0);
        end
        if (i_test_id == 5) begin
            check_loop_reads(1'b1);
        end
        if (test_errors == 0) begin
            passed++;
            $display("test %0d %s: ok", i_test_id, test_name(i_test_id));
        end else begin
            o_failed++;
            $display("test %0d %s: failed with %0d errors", i_test_id,
                     test_name(i_test_id), test_errors);
        end
        test_errors = 0;
    endtask

    always @(posedge clk) begin
        if (!rstn) begin
            expect_pc   = fetch_pkg::pc_t'(`RESET_PC);
            test_errors = 0;
            passed      = 0;
            o_failed    = 0;
        end else begin
            if (i_wb_req.cyc && i_wb_req.stb && i_wb_rsp.ack) begin
                reads[i_wb_req.adr] = reads_of(i_wb_req.adr) + 1;
            end
            // an entry popped before a redirect still carries the old pc.
            if (i_instr_valid) begin
                if (i_instr.pc != expect_pc) begin
                    $display("Error at %0t ns: got pc %h, expected pc %h",
                             $time, i_instr.pc, expect_pc);
                    test_errors++;
                end else if (i_instr.instr != mem_word(expect_pc)) begin
                    $display("Error at %0t ns: pc %h gave instr %h, expected %h",
                             $time, i_instr.pc, i_instr.instr, mem_word(expect_pc));
                    test_errors++;
                end
                expect_pc = expect_pc + fetch_pkg::pc_t'(1);
            end
            if (i_redirect) begin
                expect_pc = i_redirect_pc;
            end
            if (i_clear_reads) begin
                reads.delete();
            end
            if (i_test_done) begin
                finish_test();
            end
            if (i_report) begin
                // errors seen after the last test closed.
                if (test_errors != 0) begin
                    o_failed++;
                end
                $display("tests passed %0d, failed %0d", passed, o_failed);
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_config.svh"

module fetch_unit (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    i_redirect,
    input  wire fetch_pkg::pc_t    i_redirect_pc,
    input  wire                    i_pop,
    output fetch_pkg::fetch_entry_t o_instr,
    output logic                   o_instr_valid,
    output wb_pkg::wb_req_t        o_wb_req,
    input  wire wb_pkg::wb_rsp_t   i_wb_rsp
);

    fetch_pkg::pc_t          find_key;
    logic                    found;
    fetch_pkg::instr_t       found_data;
    logic                    fill;
    fetch_pkg::pc_t          fill_key;
    fetch_pkg::instr_t       fill_data;
    logic                    bus_start;
    fetch_pkg::pc_t          bus_addr;
    logic                    bus_done;
    fetch_pkg::instr_t       bus_data;
    logic                    push;
    fetch_pkg::fetch_entry_t push_entry;
    logic                    push_done;
    logic                    flush;

    fetch_ctrl ctrl_i (
        .clk(clk), .rstn(rstn),
        .i_redirect(i_redirect), .i_redirect_pc(i_redirect_pc),
        .o_find_key(find_key), .i_found(found), .i_found_data(found_data),
        .o_fill(fill), .o_fill_key(fill_key), .o_fill_data(fill_data),
        .o_bus_start(bus_start), .o_bus_addr(bus_addr),
        .i_bus_done(bus_done), .i_bus_data(bus_data),
        .o_push(push), .o_push_entry(push_entry), .i_push_done(push_done),
        .o_flush(flush)
    );

    fetch_cache #(.DEPTH(`CACHE_DEPTH)) cache_i (
        .clk(clk), .rstn(rstn),
        .i_push(fill), .i_push_key(fill_key), .i_push_data(fill_data),
        .i_find_key(find_key), .o_found(found), .o_found_data(found_data)
    );

    instr_queue #(.LEN_ADDR(`QUEUE_ADDR_W)) queue_i (
        .clk(clk), .rstn(rstn), .i_flush(flush),
        .i_push(push), .i_push_entry(push_entry), .o_push_done(push_done),
        .i_pop(i_pop), .o_pop_entry(o_instr), .o_pop_done(o_instr_valid)
    );

    wb_read_master bus_i (
        .clk(clk), .rstn(rstn),
        .i_start(bus_start), .i_addr(bus_addr),
        .o_done(bus_done), .o_data(bus_data),
        .o_wb_req(o_wb_req), .i_wb_rsp(i_wb_rsp)
    );

endmodule

`default_nettype wire

//--- verilog/fetch_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_config.svh"

module fetch_ctrl (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    i_redirect,
    input  wire fetch_pkg::pc_t    i_redirect_pc,
    output fetch_pkg::pc_t         o_find_key,
    input  wire                    i_found,
    input  wire fetch_pkg::instr_t i_found_data,
    output logic                   o_fill,
    output fetch_pkg::pc_t         o_fill_key,
    output fetch_pkg::instr_t      o_fill_data,
    output logic                   o_bus_start,
    output fetch_pkg::pc_t         o_bus_addr,
    input  wire                    i_bus_done,
    input  wire fetch_pkg::instr_t i_bus_data,
    output logic                   o_push,
    output fetch_pkg::fetch_entry_t o_push_entry,
    input  wire                    i_push_done,
    output logic                   o_flush
);

    fetch_pkg::ctrl_state_e state;
    fetch_pkg::pc_t         pc;
    fetch_pkg::pc_t         miss_pc;  // address of the read in flight.
    fetch_pkg::instr_t      pending;
    logic                   stale;

    assign o_find_key   = pc;
    assign o_bus_start  = (state == fetch_pkg::LOOKUP) && !i_found && !i_redirect;
    assign o_bus_addr   = pc;
    assign o_fill       = (state == fetch_pkg::BUS_WAIT) && i_bus_done;
    assign o_fill_key   = miss_pc;
    assign o_fill_data  = i_bus_data;
    assign o_push       = (state == fetch_pkg::PUSH);
    assign o_push_entry = '{pc: pc, instr: pending};
    assign o_flush      = i_redirect;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= fetch_pkg::LOOKUP;
            pc    <= fetch_pkg::pc_t'(`RESET_PC);
            stale <= 1'b0;
        end else begin
            case (state)
                fetch_pkg::LOOKUP: begin
                    if (!i_redirect) begin
                        state <= i_found ? fetch_pkg::PUSH : fetch_pkg::BUS_WAIT;
                    end
                end
                fetch_pkg::BUS_WAIT: begin
                    // a redirected read still fills the cache but is dropped here.
                    if (i_bus_done) begin
                        state <= (stale || i_redirect) ? fetch_pkg::LOOKUP : fetch_pkg::PUSH;
                        stale <= 1'b0;
                    end else if (i_redirect) begin
                        stale <= 1'b1;
                    end
                end
                fetch_pkg::PUSH: begin
                    state <= i_redirect ? fetch_pkg::LOOKUP : fetch_pkg::PUSH_ACK;
                end
                fetch_pkg::PUSH_ACK: begin
                    if (i_redirect) begin
                        state <= fetch_pkg::LOOKUP;
                    end else if (i_push_done) begin
                        pc    <= pc + 1'b1;
                        state <= fetch_pkg::LOOKUP;
                    end else begin
                        state <= fetch_pkg::PUSH;
                    end
                end
                default: state <= fetch_pkg::LOOKUP;
            endcase
            if (i_redirect) begin
                pc <= i_redirect_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state == fetch_pkg::LOOKUP) && i_found) begin
            pending <= i_found_data;
        end else if (o_fill) begin
            pending <= i_bus_data;
        end
        if (o_bus_start) begin
            miss_pc <= pc;
        end
    end

endmodule

`default_nettype wire

//--- verilog/wb_read_master.sv
`timescale 1ns/1ns
`default_nettype none

module wb_read_master (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    i_start,
    input  wire fetch_pkg::pc_t    i_addr,
    output logic                   o_done,
    output fetch_pkg::instr_t      o_data,
    output wb_pkg::wb_req_t        o_wb_req,
    input  wire wb_pkg::wb_rsp_t   i_wb_rsp
);

    wb_pkg::wb_req_t req_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_q.cyc <= 1'b0;
            req_q.stb <= 1'b0;
        end else if (i_start) begin
            req_q.cyc <= 1'b1;
            req_q.stb <= 1'b1;
            req_q.adr <= i_addr;
        end else if (i_wb_rsp.ack) begin
            req_q.cyc <= 1'b0;
            req_q.stb <= 1'b0;
        end
    end

    assign o_wb_req = req_q;
    // read data is only valid in the ack cycle.
    assign o_done   = req_q.stb && i_wb_rsp.ack;
    assign o_data   = i_wb_rsp.dat;

    a_stb_cyc: assert property (@(posedge clk) disable iff (!rstn)
        req_q.stb |-> req_q.cyc);

    a_adr_hold: assert property (@(posedge clk) disable iff (!rstn)
        (req_q.stb && !i_wb_rsp.ack) |=> $stable(req_q.adr));

endmodule

`default_nettype wire

//--- verilog/instr_queue.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_config.svh"

module instr_queue #(
    parameter int LEN_ADDR = `QUEUE_ADDR_W
) (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          i_flush,
    input  wire                          i_push,
    input  wire fetch_pkg::fetch_entry_t i_push_entry,
    output logic                         o_push_done,
    input  wire                          i_pop,
    output fetch_pkg::fetch_entry_t      o_pop_entry,
    output logic                         o_pop_done
);

    localparam int DEPTH = 2 ** LEN_ADDR;

    fetch_pkg::fetch_entry_t mem [DEPTH];
    logic [LEN_ADDR-1:0] wr_ptr;  // next slot to write.
    logic [LEN_ADDR-1:0] rd_ptr;  // next slot to read.
    logic empty;
    logic full;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr + 1'b1 == rd_ptr);

    always_ff @(posedge clk) begin
        o_push_done <= 1'b0;
        o_pop_done  <= 1'b0;
        if (!rstn || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (i_push && i_pop) begin
            // empty queue passes the new entry straight through.
            mem[wr_ptr] <= i_push_entry;
            o_pop_entry <= empty ? i_push_entry : mem[rd_ptr];
            wr_ptr      <= wr_ptr + 1'b1;
            rd_ptr      <= rd_ptr + 1'b1;
            o_push_done <= 1'b1;
            o_pop_done  <= 1'b1;
        end else if (i_push && !full) begin
            mem[wr_ptr] <= i_push_entry;
            wr_ptr      <= wr_ptr + 1'b1;
            o_push_done <= 1'b1;
        end else if (i_pop && !empty) begin
            o_pop_entry <= mem[rd_ptr];
            rd_ptr      <= rd_ptr + 1'b1;
            o_pop_done  <= 1'b1;
        end
    end

    a_no_empty_pop: assert property (@(posedge clk) disable iff (!rstn)
        (i_pop && empty && !i_push) |=> !o_pop_done);

endmodule

`default_nettype wire

//--- verilog/fetch_cache.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_config.svh"

module fetch_cache #(
    parameter int DEPTH = `CACHE_DEPTH
) (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire                     i_push,
    input  wire fetch_pkg::pc_t     i_push_key,
    input  wire fetch_pkg::instr_t  i_push_data,
    input  wire fetch_pkg::pc_t     i_find_key,
    output logic                    o_found,
    output fetch_pkg::instr_t       o_found_data
);

    localparam logic [DEPTH-1:0] ONE = 1;

    fetch_pkg::pc_t    key  [DEPTH];
    fetch_pkg::instr_t data [DEPTH];
    // row i bit j set: entry i was written after entry j. diagonal is the valid bit.
    logic [DEPTH-1:0]  prio [DEPTH];

    logic [DEPTH-1:0] push_match;
    logic [DEPTH-1:0] push_able;
    logic [DEPTH-1:0] push_place;
    logic [DEPTH-1:0] found_k;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            push_match[i] = i_push && prio[i][i] && (key[i] == i_push_key);
        end
        // an entry is a victim when nothing else is older than it.
        for (int i = 0; i < DEPTH; i++) begin
            push_able[i] = (|push_match) ? push_match[i]
                                         : (i_push && !(|(prio[i] & ~(ONE << i))));
        end
        // keep the lowest index only.
        push_place = push_able & (~push_able + ONE);
    end

    always_comb begin
        o_found_data = '0;
        for (int i = 0; i < DEPTH; i++) begin
            found_k[i] = prio[i][i] && (key[i] == i_find_key);
            if (found_k[i]) begin
                o_found_data = o_found_data | data[i];
            end
        end
    end

    assign o_found = |found_k;

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (push_place[i]) begin
                key[i]  <= i_push_key;
                data[i] <= i_push_data;
            end
        end
    end

    // lookups leave the matrix alone, so eviction stays fifo.
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (!rstn) begin
                prio[i] <= '0;
            end else begin
                prio[i] <= push_place[i] ? '1 : (prio[i] & ~push_place);
            end
        end
    end

    a_unique_hit: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0(found_k));

endmodule

`default_nettype wire

//--- verilog/fetch_pkg.sv
`default_nettype none

`include "fetch_config.svh"

package fetch_pkg;

    typedef logic [`FETCH_ADDR_W-1:0] pc_t;
    typedef logic [`INSTR_W-1:0] instr_t;

    // one fetched word and where it came from.
    typedef struct packed {
        pc_t    pc;
        instr_t instr;
    } fetch_entry_t;

    typedef enum logic [1:0] {
        LOOKUP,
        BUS_WAIT,
        PUSH,
        PUSH_ACK
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- verilog/wb_pkg.sv
`default_nettype none

`include "fetch_config.svh"

package wb_pkg;

    typedef logic [`FETCH_ADDR_W-1:0] wb_adr_t;
    typedef logic [`INSTR_W-1:0] wb_dat_t;

    // master to slave.
    typedef struct packed {
        logic    cyc;
        logic    stb;
        wb_adr_t adr;
    } wb_req_t;

    // slave to master, dat valid with ack.
    typedef struct packed {
        wb_dat_t dat;
        logic    ack;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- verilog/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// word address and instruction widths.
`define FETCH_ADDR_W 16
`define INSTR_W 32

// fetch cache entries.
`define CACHE_DEPTH 8

// the queue holds 2**QUEUE_ADDR_W - 1 entries.
`define QUEUE_ADDR_W 4

`define RESET_PC 0

`endif
